// ==== logic/qe_pkg.sv ====
package qe_pkg;

   // widths with a meaning on the shared bus
   localparam int speed_w = 16;  // tick count, also bus data width
   localparam int adr_w   = 3;   // word address, two windows of four words

   typedef logic [speed_w-1:0] speed_t;   // pulse width in ticks
   typedef logic [adr_w-1:0]   wb_adr_t;  // shared bus word address

   // offsets inside one channel window
   // channel 0 sits at base 0, channel 1 at base 4
   localparam wb_adr_t reg_speed   = 3'd0;  // last latched width
   localparam wb_adr_t reg_samples = 3'd1;  // number of speed results
   localparam wb_adr_t reg_status  = 3'd2;  // status flags

   // status bit 0 is the sticky overflow flag
   localparam speed_t status_ovf = 16'h0001;

endpackage

// ==== logic/qe_speed_fsm.sv ====
module qe_speed_fsm (
   input  logic clk,
   input  logic reset,
   input  logic a_level,      // synchronized A phase
   input  logic max_count,    // tick counter at its limit
   output logic clear_all,    // overflow, drop the measurement
   output logic count_tick,   // add one tick
   output logic load_buffer,  // latch the finished width
   output logic clear_count   // zero counter after a good result
);

   typedef enum logic [2:0] {
      st_idle,
      st_ovf_clear,
      st_limit_check,
      st_count,
      st_level_check,
      st_load,
      st_count_clear
   } qe_state_t;

   qe_state_t state;
   qe_state_t next_state;

   // state register
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= st_idle;
      end else begin
         state <= next_state;
      end
   end

   // next state, one tick per pass through the three-state loop
   always_comb begin
      next_state = state;  // hold by default
      case (state)
         st_idle:
            next_state = a_level ? st_limit_check : st_idle;  // wait for A high
         st_ovf_clear:
            next_state = st_idle;  // restart if A still high
         st_limit_check:
            next_state = max_count ? st_ovf_clear : st_count;
         st_count:
            next_state = st_level_check;
         st_level_check:
            next_state = a_level ? st_limit_check : st_load;  // falling edge ends pulse
         st_load:
            next_state = st_count_clear;
         st_count_clear:
            next_state = st_idle;
         default:
            next_state = st_idle;  // unused encoding
      endcase
   end

   // moore outputs straight from state
   assign clear_all   = (state == st_ovf_clear);
   assign count_tick  = (state == st_count);
   assign load_buffer = (state == st_load);
   assign clear_count = (state == st_count_clear);

   a_one_output: assert property (
      @(posedge clk) disable iff (!reset)
      $onehot0({clear_all, count_tick, load_buffer, clear_count})
   );

endmodule

// ==== logic/qe_speed_channel.sv ====
module qe_speed_channel #(
   parameter int speed_max = 1000,  // tick limit before overflow
   parameter int ch_base   = 0      // first word of this channel's window
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            qe_a,   // raw A phase, async to clk
   output logic            cyc,
   output logic            stb,
   output logic            we,
   output qe_pkg::wb_adr_t adr,
   output qe_pkg::speed_t  dat_w,
   input  logic            ack
);
   import qe_pkg::*;

   logic [1:0] a_sync;       // two-flop synchronizer
   logic       a_level;
   speed_t     count;        // tick counter
   logic       max_count;
   logic       clear_all;
   logic       count_tick;
   logic       load_buffer;
   logic       clear_count;
   speed_t     buffer;       // last finished width
   logic       pend;         // event waiting behind a busy write
   logic       pend_ovf;     // type of newest event, 1 = overflow
   logic       event_any;
   logic       launch;
   logic       launch_ovf;

   // both edges see the same delay so width is kept
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         a_sync <= 2'b00;
      end else begin
         a_sync <= {a_sync[0], qe_a};
      end
   end
   assign a_level = a_sync[1];

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         count <= '0;
      end else if (clear_all || clear_count) begin
         count <= '0;
      end else if (count_tick) begin
         count <= count + 1'b1;
      end
   end
   assign max_count = (count == speed_t'(speed_max));  // limit reached

   qe_speed_fsm u_fsm (
      .clk         (clk),
      .reset       (reset),
      .a_level     (a_level),
      .max_count   (max_count),
      .clear_all   (clear_all),
      .count_tick  (count_tick),
      .load_buffer (load_buffer),
      .clear_count (clear_count)
   );

   always_ff @(posedge clk) begin
      if (load_buffer) begin
         buffer <= count;  // final width held while counter clears
      end
   end

   assign event_any  = load_buffer | clear_all;
   assign launch     = !cyc && (event_any || pend);      // bus idle and work to do
   assign launch_ovf = event_any ? clear_all : pend_ovf;  // a fresh event wins

   // write master control, one write in flight at most
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         cyc      <= 1'b0;
         pend     <= 1'b0;
         pend_ovf <= 1'b0;
      end else begin
         if (cyc && ack) begin
            cyc <= 1'b0;  // drop in the cycle after ack
         end else if (launch) begin
            cyc <= 1'b1;
         end
         if (cyc && event_any) begin
            pend <= 1'b1;  // park it, older pending is overwritten
         end else if (!cyc) begin
            pend <= 1'b0;  // launched now or nothing waiting
         end
         if (event_any) begin
            pend_ovf <= clear_all;
         end
      end
   end

   // address and data frozen for the whole cycle
   always_ff @(posedge clk) begin
      if (launch) begin
         adr   <= launch_ovf ? wb_adr_t'(ch_base) + reg_status
                             : wb_adr_t'(ch_base) + reg_speed;
         dat_w <= launch_ovf ? status_ovf : (load_buffer ? count : buffer);
      end
   end

   assign stb = cyc;
   assign we  = cyc;  // channel only ever writes

   a_hold_request: assert property (
      @(posedge clk) disable iff (!reset)
      stb && !ack |=> $stable(adr) && $stable(dat_w)
   );

endmodule

// ==== logic/wb_arbiter.sv ====
module wb_arbiter (
   input  logic            clk,
   input  logic            reset,
   input  logic            m0_cyc,    // host
   input  logic            m0_stb,
   input  logic            m0_we,
   input  qe_pkg::wb_adr_t m0_adr,
   input  qe_pkg::speed_t  m0_dat_w,
   output logic            m0_ack,
   input  logic            m1_cyc,    // channel 0
   input  logic            m1_stb,
   input  logic            m1_we,
   input  qe_pkg::wb_adr_t m1_adr,
   input  qe_pkg::speed_t  m1_dat_w,
   output logic            m1_ack,
   input  logic            m2_cyc,    // channel 1
   input  logic            m2_stb,
   input  logic            m2_we,
   input  qe_pkg::wb_adr_t m2_adr,
   input  qe_pkg::speed_t  m2_dat_w,
   output logic            m2_ack,
   output logic            s_cyc,
   output logic            s_stb,
   output logic            s_we,
   output qe_pkg::wb_adr_t s_adr,
   output qe_pkg::speed_t  s_dat_w,
   input  logic            s_ack
);
   import qe_pkg::*;

   logic [2:0] req;
   logic [2:0] cyc_vec;
   logic [2:0] gnt;         // one-hot grant or zero while the bus is free
   logic [1:0] last;        // master served most recently
   logic [1:0] pick_idx;
   logic       pick_valid;
   logic       held;

   assign cyc_vec = {m2_cyc, m1_cyc, m0_cyc};
   assign req     = cyc_vec & {m2_stb, m1_stb, m0_stb};
   assign held    = |(gnt & cyc_vec);  // owner still in its cycle

   // round robin search from just after the last one served
   always_comb begin
      int unsigned cand;
      pick_valid = 1'b0;
      pick_idx   = last;
      for (int k = 1; k <= 3; k++) begin
         cand = (int'(last) + k) % 3;
         if (!pick_valid && req[cand]) begin
            pick_valid = 1'b1;
            pick_idx   = 2'(cand);
         end
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         gnt  <= 3'b000;
         last <= 2'd2;  // host goes first
      end else if (!held) begin
         gnt <= pick_valid ? (3'b001 << pick_idx) : 3'b000;
         if (pick_valid) begin
            last <= pick_idx;
         end
      end
   end

   // slave side mux
   always_comb begin
      s_cyc   = 1'b0;
      s_stb   = 1'b0;
      s_we    = 1'b0;
      s_adr   = '0;
      s_dat_w = '0;
      if (gnt[0]) begin
         s_cyc   = m0_cyc;
         s_stb   = m0_stb;
         s_we    = m0_we;
         s_adr   = m0_adr;
         s_dat_w = m0_dat_w;
      end else if (gnt[1]) begin
         s_cyc   = m1_cyc;
         s_stb   = m1_stb;
         s_we    = m1_we;
         s_adr   = m1_adr;
         s_dat_w = m1_dat_w;
      end else if (gnt[2]) begin
         s_cyc   = m2_cyc;
         s_stb   = m2_stb;
         s_we    = m2_we;
         s_adr   = m2_adr;
         s_dat_w = m2_dat_w;
      end
   end

   // ack back to the owner only
   assign m0_ack = s_ack & gnt[0];
   assign m1_ack = s_ack & gnt[1];
   assign m2_ack = s_ack & gnt[2];

   a_grant_held: assert property (
      @(posedge clk) disable iff (!reset)
      held |=> gnt == $past(gnt)
   );

endmodule

// ==== logic/speed_reg_file.sv ====
module speed_reg_file (
   input  logic            clk,
   input  logic            reset,
   input  logic            s_cyc,
   input  logic            s_stb,
   input  logic            s_we,
   input  qe_pkg::wb_adr_t s_adr,
   input  qe_pkg::speed_t  s_dat_w,
   output qe_pkg::speed_t  s_dat_r,
   output logic            s_ack
);
   import qe_pkg::*;

   speed_t  speed_q   [2];  // per channel
   speed_t  samples_q [2];
   speed_t  status_q  [2];
   logic    ch;             // window select
   wb_adr_t offset;         // word inside the window
   logic    access;         // first cycle of a strobe
   speed_t  rd_val;

   assign ch     = s_adr[2];                // windows on 4-word boundaries
   assign offset = {1'b0, s_adr[1:0]};
   assign access = s_cyc && s_stb && !s_ack;  // ack cycle is not a new access

   always_comb begin
      case (offset)
         reg_speed:   rd_val = speed_q[ch];
         reg_samples: rd_val = samples_q[ch];
         reg_status:  rd_val = status_q[ch];
         default:     rd_val = '0;  // hole at offset 3
      endcase
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         s_ack <= 1'b0;
         for (int i = 0; i < 2; i++) begin
            speed_q[i]   <= '0;
            samples_q[i] <= '0;
            status_q[i]  <= '0;
         end
      end else begin
         s_ack <= access;  // single cycle ack one cycle after stb
         if (access && s_we) begin
            case (offset)
               reg_speed: begin
                  speed_q[ch]   <= s_dat_w;
                  samples_q[ch] <= samples_q[ch] + 1'b1;  // count each result
               end
               reg_status: begin
                  // sticky flags cleared only by a write of zero
                  status_q[ch] <= (s_dat_w == '0) ? '0 : (status_q[ch] | s_dat_w);
               end
               default: ;  // samples is read only
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         s_dat_r <= rd_val;  // valid with ack
      end
   end

   // master must still hold stb while ack is up
   a_ack_after_stb: assert property (
      @(posedge clk) disable iff (!reset)
      s_ack |-> s_stb && $past(s_stb)
   );

endmodule

// ==== logic/qe_speed_top.sv ====
module qe_speed_top #(
   parameter int speed_max = 1000  // tick limit for both channels
) (
   input  logic            clk,
   input  logic            reset,
   input  logic [1:0]      qe_a,        // A phase per channel
   input  logic            host_cyc,
   input  logic            host_stb,
   input  logic            host_we,
   input  qe_pkg::wb_adr_t host_adr,
   input  qe_pkg::speed_t  host_dat_w,
   output qe_pkg::speed_t  host_dat_r,
   output logic            host_ack
);
   import qe_pkg::*;

   logic    ch0_cyc, ch0_stb, ch0_we, ch0_ack;
   wb_adr_t ch0_adr;
   speed_t  ch0_dat_w;
   logic    ch1_cyc, ch1_stb, ch1_we, ch1_ack;
   wb_adr_t ch1_adr;
   speed_t  ch1_dat_w;
   logic    s_cyc, s_stb, s_we, s_ack;
   wb_adr_t s_adr;
   speed_t  s_dat_w;
   speed_t  s_dat_r;

   qe_speed_channel #(.speed_max(speed_max), .ch_base(0)) u_ch0 (
      .clk (clk), .reset (reset), .qe_a (qe_a[0]),
      .cyc (ch0_cyc), .stb (ch0_stb), .we (ch0_we),
      .adr (ch0_adr), .dat_w (ch0_dat_w), .ack (ch0_ack)
   );

   qe_speed_channel #(.speed_max(speed_max), .ch_base(4)) u_ch1 (
      .clk (clk), .reset (reset), .qe_a (qe_a[1]),
      .cyc (ch1_cyc), .stb (ch1_stb), .we (ch1_we),
      .adr (ch1_adr), .dat_w (ch1_dat_w), .ack (ch1_ack)
   );

   // host is m0, channels follow in round-robin order
   wb_arbiter u_arb (
      .clk (clk), .reset (reset),
      .m0_cyc (host_cyc), .m0_stb (host_stb), .m0_we (host_we),
      .m0_adr (host_adr), .m0_dat_w (host_dat_w), .m0_ack (host_ack),
      .m1_cyc (ch0_cyc), .m1_stb (ch0_stb), .m1_we (ch0_we),
      .m1_adr (ch0_adr), .m1_dat_w (ch0_dat_w), .m1_ack (ch0_ack),
      .m2_cyc (ch1_cyc), .m2_stb (ch1_stb), .m2_we (ch1_we),
      .m2_adr (ch1_adr), .m2_dat_w (ch1_dat_w), .m2_ack (ch1_ack),
      .s_cyc (s_cyc), .s_stb (s_stb), .s_we (s_we),
      .s_adr (s_adr), .s_dat_w (s_dat_w), .s_ack (s_ack)
   );

   speed_reg_file u_regs (
      .clk (clk), .reset (reset),
      .s_cyc (s_cyc), .s_stb (s_stb), .s_we (s_we),
      .s_adr (s_adr), .s_dat_w (s_dat_w),
      .s_dat_r (s_dat_r), .s_ack (s_ack)
   );

   assign host_dat_r = s_dat_r;  // read data shared, only the host uses it

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen #(
   parameter int reset_cycles = 2  // clock edges with reset held low
) (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam realtime half_period = 4ns;  // 8 ns clock

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // active low, released on a rising edge
   initial begin
      reset = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b1;
   end

endmodule

// ==== tb/qe_speed_tb.sv ====
module qe_speed_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import qe_pkg::*;

   localparam int speed_max   = 20;    // small limit so overflow is quick to reach
   localparam int n_pulses    = 6;     // random pulses per channel and test
   localparam int ack_limit   = 64;    // cycles one host access may wait
   localparam int poll_limit  = 200;
   localparam int n_tests     = 5;
   localparam int test_cycles = 2000;
   localparam longint watchdog_ns = longint'(n_tests + 1) * test_cycles * 8;  // one test spare

   logic    clk;
   logic    reset;
   logic    a0;                    // A phase, channel 0
   logic    a1;                    // A phase, channel 1
   logic    host_cyc;
   logic    host_stb;
   logic    host_we;
   wb_adr_t host_adr;
   speed_t  host_dat_w;
   speed_t  host_dat_r;
   logic    host_ack;

   int          errors;
   int          checks;
   int          test_errors;       // error count when the current test began
   int          tests_run;
   logic [31:0] rng_state = 32'h40ed76cd;
   int          exp_speed   [2];   // model of the register file
   int          exp_samples [2];
   int          exp_status  [2];
   int          widths [2][n_pulses];
   int          gaps   [2][n_pulses];
   int          chans_busy;        // pulse processes still running
   int          host_txn;
   int          host_done;

   tb_clock_gen u_clk (.clk (clk), .reset (reset));

   qe_speed_top #(.speed_max(speed_max)) uut (
      .clk (clk), .reset (reset), .qe_a ({a1, a0}),
      .host_cyc (host_cyc), .host_stb (host_stb), .host_we (host_we),
      .host_adr (host_adr), .host_dat_w (host_dat_w),
      .host_dat_r (host_dat_r), .host_ack (host_ack)
   );

   // ack only inside an open host cycle
   a_host_ack_in_cycle: assert property (
      @(posedge clk) disable iff (!reset)
      host_ack |-> host_cyc && host_stb
   ) else begin
      $display("host ack arrived outside a host bus cycle");
      errors++;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int rand_range(input int lo, input int hi);
      rng_state = xorshift32(rng_state);
      return lo + int'(rng_state % (hi - lo + 1));
   endfunction

   function automatic wb_adr_t reg_adr(input int ch, input wb_adr_t offset);
      return wb_adr_t'(ch * 4) + offset;  // windows at 0 and 4
   endfunction

   // expected results of one pulse of high cycles
   task automatic model_pulse(input int ch, input int high);
      int rem;
      rem = high;
      while (rem > 0) begin
         if (rem > 3 * speed_max) begin
            exp_status[ch] = 1;           // sticky overflow
            rem -= 3 * speed_max + 3;      // fsm idle again, restarts if A still high
         end else begin
            exp_speed[ch] = (rem - 1) / 3 + 1;  // one tick per 3 cycles
            exp_samples[ch]++;
            rem = 0;
         end
      end
   endtask

   task automatic check_value(input string test_name, input string what,
                              input int expected, input int actual);
      checks++;
      assert (actual == expected) else begin
         $display("** Error %s %s expected %0d actual %0d", test_name, what, expected, actual);
         errors++;
      end
   endtask

   // one classic cycle, starts on the next edge
   task automatic host_access(input logic write, input wb_adr_t a, input speed_t wdata,
                              output speed_t rdata, output logic ok);
      int waited;
      waited = 0;
      @(posedge clk);
      host_cyc   <= 1'b1;  // cyc and stb together
      host_stb   <= 1'b1;
      host_we    <= write;
      host_adr   <= a;
      host_dat_w <= wdata;
      do begin
         @(posedge clk);
         waited++;
      end while (!host_ack && waited < ack_limit);
      ok    = host_ack;
      rdata = host_dat_r;  // valid with ack
      host_cyc <= 1'b0;    // drop in the cycle after ack
      host_stb <= 1'b0;
      host_we  <= 1'b0;
      if (!ok) begin
         $display("host access to address %0d was never acknowledged", a);
         errors++;
      end
   endtask

   // keep reading until the register shows the wanted value
   task automatic poll_until(input wb_adr_t a, input int want);
      speed_t d;
      logic   ok;
      int     polls;
      polls = 0;
      do begin
         host_access(1'b0, a, '0, d, ok);
         polls++;
      end while (int'(d) != want && polls < poll_limit);
   endtask

   task automatic check_reg(input string test_name, input int ch, input wb_adr_t offset,
                            input int expected);
      speed_t d;
      logic   ok;
      host_access(1'b0, reg_adr(ch, offset), '0, d, ok);
      check_value(test_name, $sformatf("ch%0d reg %0d", ch, offset), expected, int'(d));
   endtask

   task automatic check_channel(input string test_name, input int ch);
      check_reg(test_name, ch, reg_speed, exp_speed[ch]);
      check_reg(test_name, ch, reg_samples, exp_samples[ch]);
      check_reg(test_name, ch, reg_status, exp_status[ch]);
   endtask

   task automatic drive_pulse(input int ch, input int high, input int gap);
      @(posedge clk);
      if (ch == 0) begin
         a0 <= 1'b1;
      end else begin
         a1 <= 1'b1;
      end
      repeat (high) @(posedge clk);  // high for exactly high cycles
      if (ch == 0) begin
         a0 <= 1'b0;
      end else begin
         a1 <= 1'b0;
      end
      repeat (gap) @(posedge clk);
   endtask

   task automatic plan_pulses(input int ch, input int gap_min, input int gap_max);
      for (int i = 0; i < n_pulses; i++) begin
         widths[ch][i] = rand_range(4, 50);  // speed stays at 17 or less
         gaps[ch][i]   = rand_range(gap_min, gap_max);
         model_pulse(ch, widths[ch][i]);
      end
   endtask

   task automatic run_pulses(input int ch);
      for (int i = 0; i < n_pulses; i++) begin
         drive_pulse(ch, widths[ch][i], gaps[ch][i]);
      end
      chans_busy--;
   endtask

   task automatic end_test(input string name);
      $display("%s: %s, %0d errors", name, (errors == test_errors) ? "ok" : "failed",
               errors - test_errors);
      test_errors = errors;
      tests_run++;
   endtask

   initial begin
      #(watchdog_ns);
      $display("watchdog expired, the tests did not finish in time");
      $display("Errors found");
      $finish;
   end

   initial begin
      speed_t d;
      logic   ok;
      errors      = 0;
      checks      = 0;
      test_errors = 0;
      tests_run   = 0;
      a0          = 1'b0;
      a1          = 1'b0;
      host_cyc    = 1'b0;
      host_stb    = 1'b0;
      host_we     = 1'b0;
      host_adr    = '0;
      host_dat_w  = '0;
      for (int c = 0; c < 2; c++) begin
         exp_speed[c]   = 0;
         exp_samples[c] = 0;
         exp_status[c]  = 0;
      end
      @(posedge reset);
      @(posedge clk);

      check_value("reset_state", "host_ack", 0, int'(host_ack));
      check_channel("reset_state", 0);
      check_channel("reset_state", 1);
      end_test("reset_state");

      model_pulse(0, 25);
      drive_pulse(0, 25, 40);
      poll_until(reg_adr(0, reg_samples), exp_samples[0]);
      check_channel("single_pulse", 0);
      check_channel("single_pulse", 1);  // untouched channel
      end_test("single_pulse");

      plan_pulses(0, 40, 80);
      plan_pulses(1, 40, 80);
      chans_busy = 2;
      fork
         run_pulses(0);
         run_pulses(1);
      join
      poll_until(reg_adr(0, reg_samples), exp_samples[0]);
      poll_until(reg_adr(1, reg_samples), exp_samples[1]);
      check_channel("random_pulses", 0);
      check_channel("random_pulses", 1);
      end_test("random_pulses");

      // long enough to hit the limit, tail gives one more result
      model_pulse(1, 3 * speed_max + 10);
      drive_pulse(1, 3 * speed_max + 10, 40);
      poll_until(reg_adr(1, reg_status), exp_status[1]);
      poll_until(reg_adr(1, reg_samples), exp_samples[1]);
      check_channel("overflow", 1);
      host_access(1'b1, reg_adr(1, reg_status), '0, d, ok);  // zero clears the flag
      exp_status[1] = 0;
      check_reg("overflow", 1, reg_status, exp_status[1]);
      end_test("overflow");

      plan_pulses(0, 40, 50);
      plan_pulses(1, 40, 50);
      chans_busy = 2;
      host_txn   = 0;
      host_done  = 0;
      fork
         run_pulses(0);
         run_pulses(1);
         while (chans_busy > 0) begin
            host_access(1'b0, reg_adr(host_txn % 2, reg_speed), '0, d, ok);
            host_txn++;
            if (ok) begin
               host_done++;
            end
         end
      join
      check_value("contention", "host reads completed", host_txn, host_done);
      poll_until(reg_adr(0, reg_samples), exp_samples[0]);
      poll_until(reg_adr(1, reg_samples), exp_samples[1]);
      check_channel("contention", 0);
      check_channel("contention", 1);
      end_test("contention");

      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
logic/qe_pkg.sv
logic/qe_speed_fsm.sv
logic/qe_speed_channel.sv
logic/wb_arbiter.sv
logic/speed_reg_file.sv
logic/qe_speed_top.sv
tb/tb_clock_gen.sv
tb/qe_speed_tb.sv
